// ==== logic/mbc_macros.svh ====
// widths, cartridge header offsets and magic values for the bank controller
`ifndef MBC_MACROS_SVH
`define MBC_MACROS_SVH

// ------------------------------
// widths
// ------------------------------
`define CART_ADDR_W 16 // cpu address bus
`define ROM_BANK_W  9  // up to 512 rom banks (mbc5)
`define RAM_BANK_W  4  // up to 16 ram banks of 8 KB
`define ROM_ADDR_W  23 // rom byte address, 512 x 16 KB
`define CRAM_ADDR_W 17 // 128 KB cart ram
`define DL_ADDR_W   25 // download byte address

// ------------------------------
// header word offsets, download stream is 16 bit wide
// ------------------------------
`define HDR_CGB_ADDR  25'h142 // high byte: cgb flag
`define HDR_TYPE_ADDR 25'h146 // high: cart type, low: sgb flag
`define HDR_SIZE_ADDR 25'h148 // high: ram size, low: rom size
`define HDR_LIC_ADDR  25'h14A // high byte: old licensee

// ------------------------------
// magic values
// ------------------------------
`define RAM_EN_KEY 4'hA  // low nibble that unlocks cart ram
`define OPEN_BUS   8'hFF // what the cpu sees from a floating bus

`endif

// ==== logic/mbc_pkg.sv ====
// controller kind enum, download/bus/config/bank structs and the cpu write byte union
`include "mbc_macros.svh"

package mbc_pkg;

	// ------------------------------
	// controller kind
	// ------------------------------
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0, // plain 32 KB rom, no banking
		MBC_1    = 3'd1,
		MBC_2    = 3'd2, // built in 512 x 4 bit ram
		MBC_3    = 3'd3, // rtc registers share the ram window
		MBC_5    = 3'd4
	} mbc_kind_e;

	// one word written by the rom download stream
	typedef struct packed {
		logic                  wr;
		logic [`DL_ADDR_W-1:0] addr; // byte address, even for word writes
		logic [15:0]           data; // low byte is the even address
	} dl_word_t;

	// cpu write byte, decoded differently per register window
	typedef union packed {
		logic [7:0] rom_lo;     // 2000-3FFF, whole byte is the bank low bits
		struct packed {
			logic [3:0] rsvd;
			logic       rtc_sel; // mbc3 rtc select, bank bit 3 on mbc5
			logic [2:0] bank_lo;
		} ram_sel;              // 4000-5FFF
		struct packed {
			logic [3:0] rsvd;
			logic [3:0] key;    // 0xA enables
		} enable;               // 0000-1FFF
		struct packed {
			logic [6:0] rsvd;
			logic       mode;   // mbc1 banking mode
		} mode;                 // 6000-7FFF
	} mbc_wdata_u;

	// one cpu access, rd and wr are single cycle strobes
	typedef struct packed {
		logic                    rd;
		logic                    wr;
		logic [`CART_ADDR_W-1:0] addr;
		mbc_wdata_u              wdata;
	} cart_bus_t;

	// decoded cartridge header
	typedef struct packed {
		mbc_kind_e              kind;
		logic [`ROM_BANK_W-1:0] rom_mask; // mirrors banks beyond the rom size
		logic [`RAM_BANK_W-1:0] ram_mask;
		logic                   has_ram;
		logic                   is_cgb;
		logic                   is_sgb;
	} cart_cfg_t;

	// cpu visible bank state
	typedef struct packed {
		logic [`ROM_BANK_W-1:0] rom_bank;
		logic [`RAM_BANK_W-1:0] ram_bank;
		logic                   mbc1_mode; // 1 = ram banking mode
		logic                   rtc_mode;  // mbc3 window shows rtc
		logic                   ram_en;
	} bank_state_t;

endpackage

// ==== logic/cart_header_decode.sv ====
// cart_header_decode: header capture from the download stream and config decode
`timescale 1ns/1ps
`include "mbc_macros.svh"

module cart_header_decode import mbc_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  dl_word_t  dl,
	output cart_cfg_t cfg
);

	// raw header bytes
	logic [7:0] mbc_type;
	logic [7:0] rom_size;
	logic [7:0] ram_size;
	logic [7:0] cgb_flag;
	logic [7:0] sgb_flag;
	logic [7:0] old_lic;

	logic [`ROM_BANK_W:0] rom_mask_wide; // one bit spare for the shift

	// ------------------------------
	// capture
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mbc_type <= 8'h00;
			rom_size <= 8'h00;
			ram_size <= 8'h00;
			cgb_flag <= 8'h00;
			sgb_flag <= 8'h00;
			old_lic  <= 8'h00;
		end else if (dl.wr) begin
			case (dl.addr)
				`HDR_CGB_ADDR:  cgb_flag <= dl.data[15:8];
				`HDR_TYPE_ADDR: {mbc_type, sgb_flag} <= dl.data;
				`HDR_SIZE_ADDR: {ram_size, rom_size} <= dl.data;
				`HDR_LIC_ADDR:  old_lic <= dl.data[15:8];
				default: ; // rest of the image is not ours
			endcase
		end
	end

	// ------------------------------
	// decode
	// ------------------------------
	assign rom_mask_wide = (10'd2 << rom_size[3:0]) - 10'd1; // n+1 low ones

	always_comb begin
		case (mbc_type) inside
			[8'd1:8'd3]:   cfg.kind = MBC_1;
			[8'd5:8'd6]:   cfg.kind = MBC_2;
			[8'd15:8'd19]: cfg.kind = MBC_3; // with and without timer
			[8'd25:8'd30]: cfg.kind = MBC_5; // rumble variants included
			default:       cfg.kind = MBC_NONE;
		endcase

		// odd sizes like 0x52..0x54 land on 128 banks
		if (rom_size <= 8'd8)
			cfg.rom_mask = rom_mask_wide[`ROM_BANK_W-1:0];
		else
			cfg.rom_mask = 9'h07F;

		if (ram_size <= 8'd2)
			cfg.ram_mask = 4'h0;  // none, 2 KB or one 8 KB bank
		else if (ram_size == 8'd3)
			cfg.ram_mask = 4'h3;  // 32 KB
		else
			cfg.ram_mask = 4'hF;  // 128 KB

		cfg.has_ram = (ram_size != 8'h00) || (cfg.kind == MBC_2);
		cfg.is_cgb  = (cgb_flag == 8'h80) || (cgb_flag == 8'hC0);
		cfg.is_sgb  = (sgb_flag == 8'h03) && (old_lic == 8'h33); // sgb needs the old code
	end

	// the kind feeds both later stages, an encoding hole would misroute every access
	a_kind_legal: assert property (@(posedge clk_sys) disable iff (reset)
		cfg.kind inside {MBC_NONE, MBC_1, MBC_2, MBC_3, MBC_5})
		else $error("cart_header_decode: illegal kind %0h", cfg.kind);

endmodule

// ==== logic/mbc_bank_regs.sv ====
// mbc_bank_regs: rom/ram bank, mode and ram enable registers written by the cpu
`timescale 1ns/1ps
`include "mbc_macros.svh"

module mbc_bank_regs import mbc_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,
	input  cart_bus_t   bus,
	input  cart_cfg_t   cfg,
	output bank_state_t banks
);

	logic is_mbc1;
	logic is_mbc3;
	logic is_mbc5;

	assign is_mbc1 = (cfg.kind == MBC_1);
	assign is_mbc3 = (cfg.kind == MBC_3);
	assign is_mbc5 = (cfg.kind == MBC_5);

	// ------------------------------
	// register file
	// ------------------------------
	// the window is picked by addr[15:13], a 8 KB region each
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin // a new image starts from power-up state
			banks.rom_bank  <= 9'd1;
			banks.ram_bank  <= 4'd0;
			banks.mbc1_mode <= 1'b0;
			banks.rtc_mode  <= 1'b0;
			banks.ram_en    <= 1'b0;
		end else if (bus.wr) begin
			case (bus.addr[15:13])
				3'b000: begin // 0000-1FFF ram enable
					banks.ram_en <= (bus.wdata.enable.key == `RAM_EN_KEY);
				end
				3'b001: begin // 2000-3FFF rom bank
					if (is_mbc5) begin
						if (bus.addr[12])
							banks.rom_bank[8] <= bus.wdata.rom_lo[0]; // 3000-3FFF
						else
							banks.rom_bank[7:0] <= bus.wdata.rom_lo;
					end else if (bus.wdata.rom_lo[6:0] == 7'd0) begin
						banks.rom_bank <= 9'd1; // bank 0 is never mapped at 4000
					end else begin
						banks.rom_bank <= {2'b00, bus.wdata.rom_lo[6:0]};
					end
				end
				3'b010: begin // 4000-5FFF ram bank or rtc select
					if (is_mbc3) begin
						banks.rtc_mode <= bus.wdata.ram_sel.rtc_sel;
						if (!bus.wdata.ram_sel.rtc_sel) // bank survives an rtc select
							banks.ram_bank <= {2'b00, bus.wdata.ram_sel.bank_lo[1:0]};
					end else if (is_mbc5) begin
						banks.ram_bank <= {bus.wdata.ram_sel.rtc_sel,
							bus.wdata.ram_sel.bank_lo};
					end else begin
						banks.ram_bank <= {2'b00, bus.wdata.ram_sel.bank_lo[1:0]};
					end
				end
				3'b011: begin // 6000-7FFF banking mode
					if (is_mbc1)
						banks.mbc1_mode <= bus.wdata.mode.mode;
				end
				default: ; // ram window and above, handled by the read path
			endcase
		end
	end

	// bank 0 at 4000 only exists on mbc5, the header decode must agree with
	// the register history
	a_rom_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset || dl_active)
		(banks.rom_bank == 9'd0) |-> (cfg.kind == MBC_5))
		else $error("mbc_bank_regs: rom_bank 0 with kind %0h", cfg.kind);

endmodule

// ==== logic/cart_read_path.sv ====
// cart_read_path: rom/ram address mapping, rom fetch handshake, cart ram and read data
`timescale 1ns/1ps
`include "mbc_macros.svh"

module cart_read_path import mbc_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  cart_bus_t               bus,
	input  cart_cfg_t               cfg,
	input  bank_state_t             banks,
	output logic                    rom_req,
	output logic [`ROM_ADDR_W-2:0]  rom_addr, // 16 bit word address
	input  logic                    rom_ack,
	input  logic [15:0]             rom_data,
	output logic [7:0]              rd_data,
	output logic                    rd_valid,
	output logic                    busy
);

	logic is_rom;   // 0000-7FFF
	logic is_cram;  // A000-BFFF

	logic [`ROM_BANK_W-1:0]  rom_bank_sel;
	logic [`ROM_BANK_W-1:0]  rom_bank_eff;
	logic [`ROM_ADDR_W-1:0]  rom_byte_addr;
	logic [`RAM_BANK_W-1:0]  ram_bank_eff;
	logic [`CRAM_ADDR_W-1:0] cram_addr;

	logic [7:0] cram [2**`CRAM_ADDR_W]; // up to 16 banks of 8 KB
	logic [7:0] cram_q;

	logic rom_lsb;  // byte lane of the pending fetch
	logic rom_pend; // accepted, waiting for the last ack to drop
	logic ram_pend; // ram or open bus read in flight
	logic sel_open;
	logic sel_nib;
	logic sel_zero;

	assign is_rom  = ~bus.addr[15];
	assign is_cram = (bus.addr[15:13] == 3'b101);

	// ------------------------------
	// rom mapping
	// ------------------------------
	// mbc1 mode 0 puts the two ram bits on top of the 5 rom bits
	assign rom_bank_sel = (cfg.kind == MBC_1) ?
		{2'b00, banks.mbc1_mode ? 2'b00 : banks.ram_bank[1:0], banks.rom_bank[4:0]} :
		banks.rom_bank;
	assign rom_bank_eff = rom_bank_sel & cfg.rom_mask; // mirror small roms

	always_comb begin
		if (cfg.kind == MBC_NONE)
			rom_byte_addr = {8'd0, bus.addr[14:0]};       // flat 32 KB
		else if (!bus.addr[14])
			rom_byte_addr = {9'd0, bus.addr[13:0]};       // fixed bank 0
		else
			rom_byte_addr = {rom_bank_eff, bus.addr[13:0]}; // switchable window
	end

	// ------------------------------
	// cart ram
	// ------------------------------
	always_comb begin
		case (cfg.kind)
			MBC_1:        ram_bank_eff = banks.mbc1_mode ? (banks.ram_bank & cfg.ram_mask) : 4'd0;
			MBC_3, MBC_5: ram_bank_eff = banks.ram_bank & cfg.ram_mask;
			default:      ram_bank_eff = 4'd0; // mbc2 and plain carts, one bank
		endcase
	end
	assign cram_addr = {ram_bank_eff, bus.addr[12:0]};

	always_ff @(posedge clk_sys) begin
		if (bus.wr && is_cram)
			cram[cram_addr] <= bus.wdata;
		if (bus.rd) begin
			cram_q   <= cram[cram_addr];
			sel_open <= !is_cram || !banks.ram_en;   // disabled or unmapped
			sel_nib  <= (cfg.kind == MBC_2) && (bus.addr[15:9] == 7'b1010000);
			sel_zero <= banks.rtc_mode;              // no rtc model, reads 0
		end
		if (bus.rd && is_rom) begin // hold the fetch address for the whole handshake
			rom_addr <= rom_byte_addr[`ROM_ADDR_W-1:1];
			rom_lsb  <= rom_byte_addr[0];
		end
		if (ram_pend) begin
			if (sel_open)     rd_data <= `OPEN_BUS;
			else if (sel_nib) rd_data <= {4'hF, cram_q[3:0]}; // 4 bit ram
			else if (sel_zero) rd_data <= 8'h00;
			else              rd_data <= cram_q;
		end else if (rom_req && rom_ack) begin
			rd_data <= rom_lsb ? rom_data[15:8] : rom_data[7:0];
		end
	end

	// ------------------------------
	// read control and rom handshake
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_pend <= 1'b0;
			rom_pend <= 1'b0;
			rom_req  <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= 1'b0;
			ram_pend <= bus.rd && !is_rom; // data out two cycles after the strobe
			if (ram_pend)
				rd_valid <= 1'b1;
			if (bus.rd && is_rom) begin
				if (rom_ack)
					rom_pend <= 1'b1; // previous ack still high, wait
				else
					rom_req <= 1'b1;
			end
			if (rom_pend && !rom_ack) begin
				rom_pend <= 1'b0;
				rom_req  <= 1'b1;
			end
			if (rom_req && rom_ack) begin // data captured, release the request
				rom_req  <= 1'b0;
				rd_valid <= 1'b1;
			end
		end
	end

	assign busy = ram_pend | rom_pend | rom_req;

	// four-phase order, memory must have released the previous ack
	// by the edge that raises the request
	a_req_after_ack_low: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(rom_req) |-> !$past(rom_ack))
		else $error("cart_read_path: rom_req rose with rom_ack high");

	a_addr_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_req && $past(rom_req)) |-> $stable(rom_addr))
		else $error("cart_read_path: rom_addr moved under rom_req %h", rom_addr);

endmodule

// ==== logic/cart_mapper_top.sv ====
// cart_mapper_top: header decode, bank registers and read path of the cartridge mapper
`timescale 1ns/1ps
`include "mbc_macros.svh"

module cart_mapper_top import mbc_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	// rom download
	input  dl_word_t               dl,
	input  logic                   dl_active,
	// cpu side
	input  cart_bus_t              bus,
	output logic [7:0]             rd_data,
	output logic                   rd_valid,
	output logic                   busy,
	// external rom
	output logic                   rom_req,
	output logic [`ROM_ADDR_W-2:0] rom_addr,
	input  logic                   rom_ack,
	input  logic [15:0]            rom_data,
	output cart_cfg_t              cfg_out
);

	cart_cfg_t   cfg;   // decoded header, shared by both stages
	bank_state_t banks;

	assign cfg_out = cfg;

	// ------------------------------
	// stages
	// ------------------------------
	cart_header_decode u_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.cfg     (cfg)
	);

	mbc_bank_regs u_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.bus       (bus),
		.cfg       (cfg),
		.banks     (banks)
	);

	cart_read_path u_path (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.cfg      (cfg),
		.banks    (banks),
		.rom_req  (rom_req),
		.rom_addr (rom_addr),
		.rom_ack  (rom_ack),
		.rom_data (rom_data),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.busy     (busy)
	);

	// the cpu side must hold off while a read is outstanding
	a_no_strobe_busy: assert property (@(posedge clk_sys) disable iff (reset)
		busy |-> !(bus.rd || bus.wr))
		else $error("cart_mapper_top: strobe while busy, addr %h", bus.addr);

endmodule

// ==== verif/cart_mapper_tb.sv ====
// testbench top: clock, reset, lfsr, rom model, cpu and download stimulus, checking assertions
`timescale 1ns/1ps
`include "mbc_macros.svh"

module cart_mapper_tb import mbc_pkg::*; ();

	logic                   clk_sys;
	logic                   reset;
	dl_word_t               dl;
	logic                   dl_active;
	cart_bus_t              bus;
	logic                   rom_req;
	logic [`ROM_ADDR_W-2:0] rom_addr;  // word address
	logic                   rom_ack;
	logic [15:0]            rom_data;
	logic [7:0]             rd_data;
	logic                   rd_valid;
	logic                   busy;
	cart_cfg_t              cfg_out;

	logic [15:0] lfsr;    // galois, taps 16,14,13,11
	int          ack_cnt; // -1 while no delay is running

	cart_mapper_top DUT (
		.clk_sys (clk_sys), .reset (reset), .dl (dl), .dl_active (dl_active),
		.bus (bus), .rd_data (rd_data), .rd_valid (rd_valid), .busy (busy),
		.rom_req (rom_req), .rom_addr (rom_addr), .rom_ack (rom_ack),
		.rom_data (rom_data), .cfg_out (cfg_out)
	);

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		fail_stop($sformatf("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		int         i;
		r = 8'd0;
		for (i = 0; i < n; i++) begin // one lfsr step per bit
			r    = {r[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// rom contents: each word holds its own address times 3
	function automatic logic [7:0] rom_byte(input logic [`ROM_ADDR_W-1:0] baddr);
		logic [15:0] w;
		w = 16'(baddr[`ROM_ADDR_W-1:1]) * 16'd3;
		return baddr[0] ? w[15:8] : w[7:0]; // odd byte is the high lane
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#1; // drive and sample just after the edge
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		bus.wr           = 1'b1;
		bus.addr         = addr;
		bus.wdata.rom_lo = data;
		next_cycle();
		bus.wr = 1'b0;
	endtask

	task automatic dl_write(input logic [`DL_ADDR_W-1:0] addr, input logic [15:0] data);
		dl.wr   = 1'b1;
		dl.addr = addr;
		dl.data = data;
		next_cycle();
		dl.wr = 1'b0;
	endtask

	// download the header words, cfg is valid one cycle after the last write
	task automatic load_header(input logic [7:0] ctype, sgb, ramsz, romsz, cgb, lic,
			input cart_cfg_t exp);
		dl_active = 1'b1;
		dl_write(25'h100, 16'hFFFF); // entry point, not a header field
		dl_write(`HDR_CGB_ADDR, {cgb, 8'h00});
		dl_write(`HDR_TYPE_ADDR, {ctype, sgb});
		dl_write(`HDR_SIZE_ADDR, {ramsz, romsz});
		dl_write(`HDR_LIC_ADDR, {lic, 8'h00});
		dl_active = 1'b0;
		assert (cfg_out == exp) else value_error("cfg_out", 32'(cfg_out), 32'(exp));
	endtask

	// bank is the expected effective bank after masking
	task automatic rom_read(input logic [15:0] addr, input logic [`ROM_BANK_W-1:0] bank);
		logic [`ROM_ADDR_W-1:0] baddr;
		int                     n;
		baddr    = addr[14] ? {bank, addr[13:0]} : {9'd0, addr[13:0]};
		bus.rd   = 1'b1;
		bus.addr = addr;
		next_cycle();
		bus.rd = 1'b0;
		n      = 0;
		while (!rd_valid) begin
			assert (busy) else value_error("busy", 32'(busy), 32'h1);
			if (rom_req)
				assert (rom_addr == baddr[`ROM_ADDR_W-1:1])
				else value_error("rom_addr", 32'(rom_addr), 32'(baddr[`ROM_ADDR_W-1:1]));
			if (n == 40)
				fail_stop("timeout: rd_valid did not arrive within 40 cycles of a rom read");
			next_cycle();
			n++;
		end
		assert (!busy) else value_error("busy", 32'(busy), 32'h0);
		assert (rd_data == rom_byte(baddr))
		else value_error("rd_data", 32'(rd_data), 32'(rom_byte(baddr)));
	endtask

	task automatic ram_read(input logic [15:0] addr, input logic [7:0] exp);
		bus.rd   = 1'b1;
		bus.addr = addr;
		next_cycle();
		bus.rd = 1'b0;
		assert (busy && !rd_valid) else fail_stop("ram read: wrong busy or rd_valid after strobe");
		next_cycle(); // fixed two cycle latency
		assert (rd_valid) else value_error("rd_valid", 32'(rd_valid), 32'h1);
		assert (rd_data == exp) else value_error("rd_data", 32'(rd_data), 32'(exp));
	endtask

	// ------------------------------
	// handshake and read checks
	// ------------------------------
	a_req_ack_low: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(rom_req) |-> !$past(rom_ack)) else fail_stop("rom_req rose while rom_ack was high");
	a_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_req && !rom_ack) |=> rom_req) else fail_stop("rom_req dropped before rom_ack");
	a_req_release: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_req && rom_ack) |=> !rom_req) else fail_stop("rom_req held after rom_ack");
	a_addr_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_req && $past(rom_req)) |-> $stable(rom_addr)) else fail_stop("rom_addr moved");
	a_busy_end: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(busy) |-> rd_valid) else fail_stop("busy cleared without rd_valid");
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		rd_valid |=> !rd_valid) else fail_stop("rd_valid high for more than one cycle");

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 125 MHz
	end

	// rom model, ack after 0..3 cycles, drops ack 0..3 cycles after req is gone
	initial begin
		rom_ack  = 1'b0;
		rom_data = 16'h0000;
		lfsr     = 16'h0002; // seed
		ack_cnt  = -1;
		forever begin
			next_cycle();
			if (reset) begin
				rom_ack = 1'b0;
				ack_cnt = -1;
			end else if (rom_ack) begin
				if (!rom_req) begin
					if (ack_cnt < 0)
						ack_cnt = int'(rand_bits(2)); // slow release
					if (ack_cnt == 0) begin
						rom_ack = 1'b0;
						ack_cnt = -1;
					end else begin
						ack_cnt = ack_cnt - 1;
					end
				end
			end else if (rom_req) begin
				if (ack_cnt < 0)
					ack_cnt = int'(rand_bits(2));
				if (ack_cnt == 0) begin
					rom_data = 16'(rom_addr) * 16'd3;
					rom_ack  = 1'b1;
					ack_cnt  = -1;
				end else begin
					ack_cnt = ack_cnt - 1;
				end
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		int i;
		reset     = 1'b1;
		dl        = '0;
		dl_active = 1'b0;
		bus       = '0;
		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		assert (!rom_req && !rd_valid && !busy) else fail_stop("outputs not idle after reset");
		assert (cfg_out.kind == MBC_NONE) else value_error("cfg_out.kind", 32'(cfg_out.kind), 32'h0);
		rom_read(16'h5678, 9'd1); // flat 32 KB without a controller

		// mbc1, 32 banks, 32 KB ram, cgb and sgb
		load_header(8'h03, 8'h03, 8'h03, 8'h04, 8'h80, 8'h33,
			cart_cfg_t'{MBC_1, 9'h01F, 4'h3, 1'b1, 1'b1, 1'b1});
		rom_read(16'h4123, 9'd1);  // reset bank
		cpu_write(16'h2000, 8'h00);
		rom_read(16'h4123, 9'd1);  // 0 reads as 1
		cpu_write(16'h2000, 8'h25);
		rom_read(16'h5555, 9'h005); // wraps at the mask
		cpu_write(16'h2000, 8'h1F);
		rom_read(16'h0ABC, 9'd0);   // fixed window
		for (i = 0; i < 8; i++)
			rom_read(16'h4000 | ((16'(i) * 16'h0731) & 16'h3FFF), 9'h01F);
		ram_read(16'hA010, 8'hFF);  // ram still locked
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h6000, 8'h01); // ram banking mode
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'hA010, 8'h5A);
		ram_read(16'hA010, 8'h5A);
		cpu_write(16'h4000, 8'h01);
		cpu_write(16'hA010, 8'hC3);
		ram_read(16'hA010, 8'hC3);
		cpu_write(16'h4000, 8'h02);
		ram_read(16'hA010, 8'h5A); // bank 2 untouched
		cpu_write(16'h0000, 8'h00);
		ram_read(16'hA010, 8'hFF);

		// mbc1 with 128 banks, ram bits on top in mode 0
		load_header(8'h01, 8'h00, 8'h03, 8'h06, 8'h00, 8'h00,
			cart_cfg_t'{MBC_1, 9'h07F, 4'h3, 1'b1, 1'b0, 1'b0});
		cpu_write(16'h2000, 8'h03);
		cpu_write(16'h4000, 8'h02);
		rom_read(16'h4800, 9'h043);
		cpu_write(16'h6000, 8'h01);
		rom_read(16'h4800, 9'h003);

		// mbc5, 512 banks, 128 KB ram
		load_header(8'h19, 8'h00, 8'h04, 8'h08, 8'hC0, 8'h33,
			cart_cfg_t'{MBC_5, 9'h1FF, 4'hF, 1'b1, 1'b1, 1'b0});
		cpu_write(16'h3000, 8'h01);
		cpu_write(16'h2000, 8'h23);
		rom_read(16'h7FFE, 9'h123);
		cpu_write(16'h3000, 8'h00);
		cpu_write(16'h2000, 8'h00);
		rom_read(16'h4001, 9'h000); // bank 0 allowed here
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h09);
		cpu_write(16'hB123, 8'hA5);
		ram_read(16'hB123, 8'hA5);

		// mbc2, nibble ram
		load_header(8'h06, 8'h00, 8'h00, 8'h02, 8'h00, 8'h00,
			cart_cfg_t'{MBC_2, 9'h007, 4'h0, 1'b1, 1'b0, 1'b0});
		cpu_write(16'h2100, 8'h0A);
		rom_read(16'h4000, 9'h002);
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA005, 8'h3C);
		ram_read(16'hA005, 8'hFC);

		// mbc3, rtc select reads 0 and keeps the ram bank
		load_header(8'h13, 8'h00, 8'h03, 8'h05, 8'h00, 8'h00,
			cart_cfg_t'{MBC_3, 9'h03F, 4'h3, 1'b1, 1'b0, 1'b0});
		cpu_write(16'h2000, 8'h45);
		rom_read(16'h7000, 9'h005);
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'hA100, 8'h77);
		ram_read(16'hA100, 8'h77);
		cpu_write(16'h4000, 8'h08);
		ram_read(16'hA100, 8'h00);
		cpu_write(16'h4000, 8'h02);
		ram_read(16'hA100, 8'h77);
		cpu_write(16'h0000, 8'h00);
		ram_read(16'hA100, 8'hFF);

		next_cycle();
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/mbc_pkg.sv
logic/cart_header_decode.sv
logic/mbc_bank_regs.sv
logic/cart_read_path.sv
logic/cart_mapper_top.sv
verif/cart_mapper_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = cart_mapper_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Done: errors found
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: FAIL, no verdict in $(LOG)"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
